// ==== filelist.f ====
logic/mipsPkg.sv
logic/controlUnit.sv
logic/regFile.sv
logic/fetchStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/mipsCore.sv
bench/clockGen.sv
bench/mipsCore_assert.sv
bench/mipsCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module mipsCoreTb \
	-f filelist.f \
	-o mipsCoreSim

./obj_dir/mipsCoreSim

// ==== bench/mipsCoreTb.sv ====
`timescale 1ns/1ps

module mipsCoreTb;

	typedef struct packed {
		mipsPkg::ioPort_t port;
		mipsPkg::word_t data;
	} ioEvent_t;

	localparam int PROG_WORDS = 256;
	localparam int DRAIN_LIMIT = 4000;
	localparam int START_LIMIT = 200;

	logic clk;
	logic porReset;
	logic tbReset;
	logic reset;
	logic progWe;
	mipsPkg::word_t progAddr;
	mipsPkg::word_t progData;
	logic ioValid;
	mipsPkg::ioPort_t ioPort;
	mipsPkg::word_t ioData;

	mipsPkg::word_t prog [PROG_WORDS];
	mipsPkg::word_t dmemRef [mipsPkg::DMEM_WORDS];
	int progLen;
	int outPort;
	int received;
	mipsPkg::word_t seed;
	ioEvent_t expQ [$];

	assign reset = porReset | tbReset;

	clockGen i_clockGen (
		.clk(clk),
		.reset(porReset)
	);

	mipsCore i_mipsCore (
		.clk(clk),
		.reset(reset),
		.progWe(progWe),
		.progAddr(progAddr),
		.progData(progData),
		.ioValid(ioValid),
		.ioPort(ioPort),
		.ioData(ioData)
	);

	function automatic void stopWithFailure(string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endfunction

	function automatic mipsPkg::word_t nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic mipsPkg::word_t rOp(logic [5:0] fn, mipsPkg::regAddr_t rd,
		mipsPkg::regAddr_t rs, mipsPkg::regAddr_t rt, logic [4:0] sh);
		return {mipsPkg::OP_RTYPE, rs, rt, rd, sh, fn};
	endfunction

	function automatic mipsPkg::word_t iOp(logic [5:0] op, mipsPkg::regAddr_t rt,
		mipsPkg::regAddr_t rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mipsPkg::word_t jOp(logic [5:0] op, mipsPkg::word_t addr);
		return {op, addr[27:2]};
	endfunction

	function automatic void emit(mipsPkg::word_t w);
		prog[progLen] = w;
		progLen++;
	endfunction

	// store a register to the next output port, r30 holds the port base
	function automatic void putIo(mipsPkg::regAddr_t rt);
		mipsPkg::ioPort_t p;
		p = mipsPkg::ioPort_t'(outPort);
		emit(iOp(mipsPkg::OP_SW, rt, 5'd30, {6'd0, p, 2'b00}));
		outPort++;
	endfunction

	function automatic void loadConst(mipsPkg::regAddr_t rd, mipsPkg::word_t v);
		emit(iOp(mipsPkg::OP_LUI, rd, 5'd0, v[31:16]));
		emit(iOp(mipsPkg::OP_ORI, rd, rd, v[15:0]));
	endfunction

	function automatic void startProg();
		for (int i = 0; i < PROG_WORDS; i++) begin
			prog[i] = '0;
		end
		progLen = 0;
		outPort = 0;
		emit(iOp(mipsPkg::OP_LUI, 5'd30, 5'd0, 16'h8000));
	endfunction

	// jump to self with a nop delay slot
	function automatic void finishProg();
		emit(jOp(mipsPkg::OP_J, mipsPkg::word_t'(progLen * 4)));
		emit('0);
	endfunction

	function automatic void buildAlu();
		mipsPkg::word_t r;
		startProg();
		loadConst(5'd1, nextRand());
		loadConst(5'd2, nextRand());
		loadConst(5'd3, nextRand() | 32'h8000_0000);
		loadConst(5'd4, nextRand());
		emit(rOp(mipsPkg::FN_ADDU, 5'd5, 5'd1, 5'd2, 5'd0));
		putIo(5'd5);
		emit(rOp(mipsPkg::FN_SUBU, 5'd5, 5'd1, 5'd2, 5'd0));
		putIo(5'd5);
		emit(rOp(mipsPkg::FN_AND, 5'd5, 5'd1, 5'd4, 5'd0));
		putIo(5'd5);
		emit(rOp(mipsPkg::FN_OR, 5'd5, 5'd2, 5'd4, 5'd0));
		putIo(5'd5);
		emit(rOp(mipsPkg::FN_XOR, 5'd5, 5'd1, 5'd3, 5'd0));
		putIo(5'd5);
		emit(rOp(mipsPkg::FN_NOR, 5'd5, 5'd2, 5'd3, 5'd0));
		putIo(5'd5);
		emit(rOp(mipsPkg::FN_SLT, 5'd5, 5'd3, 5'd1, 5'd0));
		putIo(5'd5);
		emit(rOp(mipsPkg::FN_SLT, 5'd5, 5'd1, 5'd3, 5'd0));
		putIo(5'd5);
		emit(rOp(mipsPkg::FN_SLTU, 5'd5, 5'd3, 5'd1, 5'd0));
		putIo(5'd5);
		emit(rOp(mipsPkg::FN_SLTU, 5'd5, 5'd1, 5'd2, 5'd0));
		putIo(5'd5);
		r = nextRand();
		emit(rOp(mipsPkg::FN_SLL, 5'd5, 5'd0, 5'd2, r[4:0]));
		putIo(5'd5);
		emit(rOp(mipsPkg::FN_SRL, 5'd5, 5'd0, 5'd3, r[9:5]));
		putIo(5'd5);
		emit(rOp(mipsPkg::FN_SRA, 5'd5, 5'd0, 5'd3, r[14:10]));
		putIo(5'd5);
		r = nextRand();
		emit(iOp(mipsPkg::OP_ADDIU, 5'd5, 5'd1, r[15:0]));
		putIo(5'd5);
		emit(iOp(mipsPkg::OP_ANDI, 5'd5, 5'd2, r[31:16]));
		putIo(5'd5);
		r = nextRand();
		emit(iOp(mipsPkg::OP_ORI, 5'd5, 5'd3, r[15:0]));
		putIo(5'd5);
		emit(iOp(mipsPkg::OP_XORI, 5'd5, 5'd4, r[31:16]));
		putIo(5'd5);
		r = nextRand();
		emit(iOp(mipsPkg::OP_SLTI, 5'd5, 5'd3, r[15:0]));
		putIo(5'd5);
		emit(iOp(mipsPkg::OP_SLTIU, 5'd5, 5'd1, r[31:16]));
		putIo(5'd5);
		emit(iOp(mipsPkg::OP_LUI, 5'd5, 5'd0, r[23:8]));
		putIo(5'd5);
		finishProg();
	endfunction

	function automatic void buildForward();
		startProg();
		loadConst(5'd1, nextRand());
		loadConst(5'd2, nextRand());
		emit(rOp(mipsPkg::FN_ADDU, 5'd5, 5'd1, 5'd2, 5'd0));
		emit(rOp(mipsPkg::FN_ADDU, 5'd6, 5'd5, 5'd1, 5'd0));
		emit(rOp(mipsPkg::FN_SUBU, 5'd7, 5'd6, 5'd5, 5'd0));
		putIo(5'd7);
		emit(iOp(mipsPkg::OP_SW, 5'd6, 5'd0, 16'h0200));
		emit(iOp(mipsPkg::OP_LW, 5'd8, 5'd0, 16'h0200));
		emit(rOp(mipsPkg::FN_ADDU, 5'd9, 5'd8, 5'd2, 5'd0));
		putIo(5'd9);
		emit(iOp(mipsPkg::OP_LW, 5'd10, 5'd0, 16'h0200));
		putIo(5'd10);
		emit(iOp(mipsPkg::OP_LW, 5'd11, 5'd0, 16'h0200));
		emit(iOp(mipsPkg::OP_SW, 5'd11, 5'd0, 16'h0204));
		emit(iOp(mipsPkg::OP_LW, 5'd12, 5'd0, 16'h0204));
		putIo(5'd12);
		emit(iOp(mipsPkg::OP_ORI, 5'd5, 5'd5, 16'h5a3c));
		emit(rOp(mipsPkg::FN_XOR, 5'd5, 5'd5, 5'd1, 5'd0));
		putIo(5'd5);
		finishProg();
	endfunction

	function automatic void buildBytes();
		startProg();
		emit(iOp(mipsPkg::OP_ADDIU, 5'd20, 5'd0, 16'h0100));
		// mix of negative and positive bytes
		loadConst(5'd1, (nextRand() | 32'h8000_8000) & 32'hff7f_ff7f);
		loadConst(5'd2, nextRand());
		emit(iOp(mipsPkg::OP_SW, 5'd1, 5'd20, 16'h0000));
		for (int k = 0; k < 4; k++) begin
			emit(iOp(mipsPkg::OP_LB, 5'd5, 5'd20, 16'(k)));
			putIo(5'd5);
			emit(iOp(mipsPkg::OP_LBU, 5'd5, 5'd20, 16'(k)));
			putIo(5'd5);
		end
		emit(iOp(mipsPkg::OP_SW, 5'd1, 5'd20, 16'h0004));
		for (int k = 0; k < 4; k++) begin
			emit(iOp(mipsPkg::OP_SB, 5'd2, 5'd20, 16'(4 + k)));
			emit(iOp(mipsPkg::OP_LW, 5'd6, 5'd20, 16'h0004));
			putIo(5'd6);
			emit(rOp(mipsPkg::FN_SRL, 5'd2, 5'd0, 5'd2, 5'd8));
		end
		finishProg();
	endfunction

	function automatic void buildFlow();
		startProg();
		emit(iOp(mipsPkg::OP_ADDIU, 5'd10, 5'd0, 16'd1));
		emit(iOp(mipsPkg::OP_BEQ, 5'd10, 5'd10, 16'd2));
		emit(iOp(mipsPkg::OP_ADDIU, 5'd11, 5'd0, 16'd5));
		putIo(5'd10);
		putIo(5'd11);
		emit(iOp(mipsPkg::OP_BNE, 5'd10, 5'd10, 16'd2));
		emit(iOp(mipsPkg::OP_ADDIU, 5'd11, 5'd11, 16'd1));
		putIo(5'd11);
		emit(iOp(mipsPkg::OP_BEQ, 5'd0, 5'd10, 16'd1));
		emit(iOp(mipsPkg::OP_ADDIU, 5'd11, 5'd11, 16'd1));
		emit(iOp(mipsPkg::OP_BNE, 5'd0, 5'd10, 16'd2));
		emit(iOp(mipsPkg::OP_ADDIU, 5'd11, 5'd11, 16'd2));
		putIo(5'd10);
		putIo(5'd11);
		// call into the subroutine at word 200
		emit(jOp(mipsPkg::OP_JAL, 32'h0000_0320));
		emit(iOp(mipsPkg::OP_ADDIU, 5'd13, 5'd0, 16'd3));
		putIo(5'd12);
		putIo(5'd13);
		emit(jOp(mipsPkg::OP_J, mipsPkg::word_t'((progLen + 3) * 4)));
		emit(iOp(mipsPkg::OP_ADDIU, 5'd14, 5'd0, 16'd9));
		putIo(5'd0);
		putIo(5'd14);
		finishProg();
		progLen = 200;
		putIo(5'd31);
		emit(iOp(mipsPkg::OP_ADDIU, 5'd12, 5'd0, 16'd7));
		emit(rOp(mipsPkg::FN_JR, 5'd0, 5'd31, 5'd0, 5'd0));
		emit(iOp(mipsPkg::OP_ADDIU, 5'd12, 5'd12, 16'd1));
	endfunction

	// instruction-level model with one delay slot per branch or jump
	function automatic void interpret();
		mipsPkg::word_t regs [32];
		mipsPkg::word_t pc;
		mipsPkg::word_t npc;
		mipsPkg::word_t nnpc;
		mipsPkg::word_t seqPc;
		mipsPkg::word_t ins;
		mipsPkg::word_t a;
		mipsPkg::word_t b;
		mipsPkg::word_t simm;
		mipsPkg::word_t zimm;
		mipsPkg::word_t target;
		mipsPkg::word_t addr;
		mipsPkg::word_t memWord;
		mipsPkg::word_t shifted;
		mipsPkg::word_t res;
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] sh;
		mipsPkg::regAddr_t dst;
		logic wr;
		logic done;
		int steps;
		ioEvent_t ev;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		pc = mipsPkg::RESET_PC;
		npc = pc + 32'd4;
		done = 1'b0;
		steps = 0;
		while (!done) begin
			ins = prog[pc[9:2]];
			op = ins[31:26];
			fn = ins[5:0];
			sh = ins[10:6];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			simm = {{16{ins[15]}}, ins[15:0]};
			zimm = {16'd0, ins[15:0]};
			seqPc = pc + 32'd4;
			target = {seqPc[31:28], ins[25:0], 2'b00};
			addr = a + simm;
			memWord = dmemRef[addr[11:2]];
			shifted = memWord >> {addr[1:0], 3'b000};
			nnpc = npc + 32'd4;
			wr = 1'b0;
			dst = ins[20:16];
			res = '0;
			case (op)
				mipsPkg::OP_RTYPE: begin
					wr = 1'b1;
					dst = ins[15:11];
					case (fn)
						mipsPkg::FN_ADDU: res = a + b;
						mipsPkg::FN_SUBU: res = a - b;
						mipsPkg::FN_AND: res = a & b;
						mipsPkg::FN_OR: res = a | b;
						mipsPkg::FN_XOR: res = a ^ b;
						mipsPkg::FN_NOR: res = ~(a | b);
						mipsPkg::FN_SLT: res = {31'd0, $signed(a) < $signed(b)};
						mipsPkg::FN_SLTU: res = {31'd0, a < b};
						mipsPkg::FN_SLL: res = b << sh;
						mipsPkg::FN_SRL: res = b >> sh;
						mipsPkg::FN_SRA: res = $signed(b) >>> sh;
						mipsPkg::FN_JR: begin
							wr = 1'b0;
							nnpc = a;
						end
						default: wr = 1'b0;
					endcase
				end
				mipsPkg::OP_J: begin
					if (target == pc) begin
						done = 1'b1;
					end
					nnpc = target;
				end
				mipsPkg::OP_JAL: begin
					nnpc = target;
					wr = 1'b1;
					dst = 5'd31;
					res = pc + 32'd8;
				end
				mipsPkg::OP_BEQ: if (a == b) nnpc = pc + 32'd4 + (simm << 2);
				mipsPkg::OP_BNE: if (a != b) nnpc = pc + 32'd4 + (simm << 2);
				mipsPkg::OP_ADDIU: {wr, res} = {1'b1, a + simm};
				mipsPkg::OP_SLTI: {wr, res} = {1'b1, 31'd0, $signed(a) < $signed(simm)};
				mipsPkg::OP_SLTIU: {wr, res} = {1'b1, 31'd0, a < simm};
				mipsPkg::OP_ANDI: {wr, res} = {1'b1, a & zimm};
				mipsPkg::OP_ORI: {wr, res} = {1'b1, a | zimm};
				mipsPkg::OP_XORI: {wr, res} = {1'b1, a ^ zimm};
				mipsPkg::OP_LUI: {wr, res} = {1'b1, ins[15:0], 16'd0};
				mipsPkg::OP_LW: {wr, res} = {1'b1, memWord};
				mipsPkg::OP_LB: {wr, res} = {1'b1, {24{shifted[7]}}, shifted[7:0]};
				mipsPkg::OP_LBU: {wr, res} = {1'b1, 24'd0, shifted[7:0]};
				mipsPkg::OP_SW, mipsPkg::OP_SB: begin
					if (op == mipsPkg::OP_SB) begin
						res = {24'd0, b[7:0]} << {addr[1:0], 3'b000};
						memWord = (memWord & ~(32'hff << {addr[1:0], 3'b000})) | res;
					end else begin
						res = b;
						memWord = b;
					end
					if (addr[31:28] == mipsPkg::IO_REGION) begin
						ev.port = addr[9:2];
						ev.data = res;
						expQ.push_back(ev);
					end else begin
						dmemRef[addr[11:2]] = memWord;
					end
				end
				default: ;
			endcase
			if (wr && dst != 5'd0) begin
				regs[dst] = res;
			end
			pc = npc;
			npc = nnpc;
			steps++;
			if (steps > 20000) begin
				stopWithFailure("reference model never reached the final jump");
			end
		end
	endfunction

	task automatic stepCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic checkPort(input mipsPkg::ioPort_t got, input mipsPkg::ioPort_t exp);
		if (got !== exp) begin
			stopWithFailure($sformatf("error at %0t: ioPort got %h, expected %h",
				$time, got, exp));
		end
	endtask

	task automatic checkWord(input mipsPkg::word_t got, input mipsPkg::word_t exp);
		if (got !== exp) begin
			stopWithFailure($sformatf("error at %0t: ioData got %h, expected %h",
				$time, got, exp));
		end
	endtask

	// program words are written while reset is held
	task automatic loadProgram();
		for (int i = 0; i < progLen; i++) begin
			stepCycle();
			progWe = 1'b1;
			progAddr = mipsPkg::word_t'(i * 4);
			progData = prog[i];
		end
		stepCycle();
		progWe = 1'b0;
	endtask

	task automatic waitDrain();
		int cycles;
		cycles = 0;
		while (expQ.size() != 0) begin
			stepCycle();
			cycles++;
			if (cycles > DRAIN_LIMIT) begin
				stopWithFailure($sformatf("timeout: %0d expected outputs never appeared",
					expQ.size()));
			end
		end
		// quiet period, any extra pulse is caught by the compare process
		repeat (20) stepCycle();
	endtask

	task automatic runProgram();
		stepCycle();
		tbReset = 1'b1;
		expQ.delete();
		interpret();
		loadProgram();
		stepCycle();
		tbReset = 1'b0;
		waitDrain();
	endtask

	task automatic restartRun();
		int cycles;
		buildFlow();
		stepCycle();
		tbReset = 1'b1;
		expQ.delete();
		interpret();
		loadProgram();
		received = 0;
		stepCycle();
		tbReset = 1'b0;
		cycles = 0;
		while (received < 3) begin
			stepCycle();
			cycles++;
			if (cycles > START_LIMIT) begin
				stopWithFailure("timeout: first outputs before the restart never appeared");
			end
		end
		stepCycle();
		tbReset = 1'b1;
		repeat (6) stepCycle();
		expQ.delete();
		interpret();
		stepCycle();
		tbReset = 1'b0;
		waitDrain();
	endtask

	// compare process, outputs are stable at the falling edge
	initial begin
		ioEvent_t ev;
		logic resetPrev;
		resetPrev = 1'b1;
		forever begin
			@(negedge clk);
			if (reset) begin
				if (resetPrev && ioValid) begin
					stopWithFailure("ioValid pulsed while reset was held high");
				end
			end else if (ioValid) begin
				if (expQ.size() == 0) begin
					stopWithFailure("ioValid arrived after all expected outputs were seen");
				end else begin
					ev = expQ.pop_front();
					checkPort(ioPort, ev.port);
					checkWord(ioData, ev.data);
					received++;
				end
			end
			resetPrev = reset;
		end
	end

	initial begin
		int cycles;
		tbReset = 1'b1;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		seed = 32'h24d9_c993;
		progLen = 0;
		outPort = 0;
		received = 0;
		cycles = 0;
		while (porReset !== 1'b0) begin
			stepCycle();
			cycles++;
			if (cycles > 20) begin
				stopWithFailure("power-on reset never released");
			end
		end
		buildAlu();
		runProgram();
		buildForward();
		runProgram();
		buildBytes();
		runProgram();
		buildFlow();
		runProgram();
		restartRun();
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== bench/mipsCore_assert.sv ====
`timescale 1ns/1ps

module mipsCoreAssert (
	input logic clk,
	input logic reset,
	input logic ioValid,
	input mipsPkg::word_t pc
);

	// the first cycle of reset may still show a store leaving stage three
	heldResetQuiet: assert property (@(posedge clk) reset && $past(reset) |-> !ioValid)
		else $error("ioValid high while reset held");

	firstCycleQuiet: assert property (@(posedge clk) $fell(reset) |-> !ioValid)
		else $error("ioValid high in first cycle after reset");

	pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else $error("fetch pc not word aligned");

endmodule

bind mipsCore mipsCoreAssert i_mipsCoreAssert (
	.clk(clk),
	.reset(reset),
	.ioValid(ioValid),
	.pc(i_fetchStage.pc)
);

// ==== bench/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// power-on reset, released just after the third edge
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

// ==== logic/mipsCore.sv ====
`timescale 1ns/1ps

module mipsCore (
	input logic clk,
	input logic reset,
	input logic progWe,
	input mipsPkg::word_t progAddr,
	input mipsPkg::word_t progData,
	output logic ioValid,
	output mipsPkg::ioPort_t ioPort,
	output mipsPkg::word_t ioData
);

	mipsPkg::fetchOut_t fetchOut;
	mipsPkg::execOut_t execOut;
	mipsPkg::wbPath_t wb;
	logic redirectValid;
	mipsPkg::word_t redirectPc;

	fetchStage i_fetchStage (
		.clk(clk),
		.reset(reset),
		.progWe(progWe),
		.progAddr(progAddr),
		.progData(progData),
		.redirectValid(redirectValid),
		.redirectPc(redirectPc),
		.fetchOut(fetchOut)
	);

	executeStage i_executeStage (
		.clk(clk),
		.reset(reset),
		.fetchOut(fetchOut),
		.wb(wb),
		.redirectValid(redirectValid),
		.redirectPc(redirectPc),
		.execOut(execOut)
	);

	memoryStage i_memoryStage (
		.clk(clk),
		.reset(reset),
		.execOut(execOut),
		.wb(wb),
		.ioValid(ioValid),
		.ioPort(ioPort),
		.ioData(ioData)
	);

endmodule

// ==== logic/memoryStage.sv ====
`timescale 1ns/1ps

module memoryStage (
	input logic clk,
	input logic reset,
	input mipsPkg::execOut_t execOut,
	output mipsPkg::wbPath_t wb,
	output logic ioValid,
	output mipsPkg::ioPort_t ioPort,
	output mipsPkg::word_t ioData
);

	logic [3:0][7:0] dmem [mipsPkg::DMEM_WORDS];
	logic [mipsPkg::DMEM_AW-1:0] wordAddr;
	logic [3:0] byteEn;
	mipsPkg::word_t loadWord;
	logic [7:0] loadByte;
	mipsPkg::word_t loadValue;
	logic isLoad;

	assign wordAddr = execOut.result[mipsPkg::DMEM_AW+1:2];

	// output port stores never reach the RAM
	always_comb begin
		case (execOut.memOp)
			mipsPkg::MEM_SW: byteEn = 4'b1111;
			mipsPkg::MEM_SB: byteEn = 4'b0001 << execOut.result[1:0];
			default: byteEn = 4'b0000;
		endcase
		if (execOut.isIo) begin
			byteEn = 4'b0000;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < 4; i++) begin
				if (byteEn[i]) begin
					dmem[wordAddr][i] <= execOut.storeData[8*i +: 8];
				end
			end
		end
	end

	// read during stage three so loads can forward back to stage two
	assign loadWord = dmem[wordAddr];
	assign loadByte = loadWord[8*execOut.result[1:0] +: 8];

	always_comb begin
		case (execOut.memOp)
			mipsPkg::MEM_LB: loadValue = {{24{loadByte[7]}}, loadByte};
			mipsPkg::MEM_LBU: loadValue = {24'd0, loadByte};
			default: loadValue = loadWord;
		endcase
	end

	assign isLoad = (execOut.memOp == mipsPkg::MEM_LW) || (execOut.memOp == mipsPkg::MEM_LB)
		|| (execOut.memOp == mipsPkg::MEM_LBU);

	always_comb begin
		wb.regWrite = execOut.regWrite;
		wb.wrAddr = execOut.wbAddr;
		if (execOut.link) begin
			wb.wrData = execOut.linkValue;
		end else if (isLoad) begin
			wb.wrData = loadValue;
		end else begin
			wb.wrData = execOut.result;
		end
	end

	assign ioValid = execOut.isIo;
	assign ioPort = execOut.result[9:2];
	assign ioData = execOut.storeData;

endmodule

// ==== logic/executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
	input logic clk,
	input logic reset,
	input mipsPkg::fetchOut_t fetchOut,
	input mipsPkg::wbPath_t wb,
	output logic redirectValid,
	output mipsPkg::word_t redirectPc,
	output mipsPkg::execOut_t execOut
);

	mipsPkg::ctrl_t ctrl;
	mipsPkg::word_t instr;
	mipsPkg::word_t pcPlus4;
	mipsPkg::word_t rsRaw;
	mipsPkg::word_t rtRaw;
	mipsPkg::word_t rsVal;
	mipsPkg::word_t rtVal;
	mipsPkg::word_t simm;
	mipsPkg::word_t opB;
	mipsPkg::word_t aluResult;
	mipsPkg::word_t storeData;
	mipsPkg::regAddr_t rsAddr;
	mipsPkg::regAddr_t rtAddr;
	mipsPkg::regAddr_t destAddr;
	logic isStore;
	mipsPkg::execOut_t execNext;

	assign instr = fetchOut.instr;
	assign rsAddr = instr[25:21];
	assign rtAddr = instr[20:16];
	assign pcPlus4 = fetchOut.pc + 32'd4;
	assign simm = {{16{instr[15]}}, instr[15:0]};

	controlUnit i_controlUnit (
		.instr(instr),
		.ctrl(ctrl)
	);

	regFile i_regFile (
		.clk(clk),
		.raddr1(rsAddr),
		.raddr2(rtAddr),
		.rdata1(rsRaw),
		.rdata2(rtRaw),
		.wb(wb)
	);

	// stage three result, including load data, bypasses the register file
	assign rsVal = (wb.regWrite && wb.wrAddr != 5'd0 && wb.wrAddr == rsAddr) ? wb.wrData : rsRaw;
	assign rtVal = (wb.regWrite && wb.wrAddr != 5'd0 && wb.wrAddr == rtAddr) ? wb.wrData : rtRaw;

	always_comb begin
		case (ctrl.srcB)
			mipsPkg::SRCB_SIMM: opB = simm;
			mipsPkg::SRCB_ZIMM: opB = {16'd0, instr[15:0]};
			mipsPkg::SRCB_SHAMT: opB = {27'd0, instr[10:6]};
			default: opB = rtVal;
		endcase
	end

	// shifts act on rt, amount in opB
	always_comb begin
		case (ctrl.aluOp)
			mipsPkg::ALU_SUB: aluResult = rsVal - opB;
			mipsPkg::ALU_AND: aluResult = rsVal & opB;
			mipsPkg::ALU_OR: aluResult = rsVal | opB;
			mipsPkg::ALU_XOR: aluResult = rsVal ^ opB;
			mipsPkg::ALU_NOR: aluResult = ~(rsVal | opB);
			mipsPkg::ALU_SLT: aluResult = {31'd0, $signed(rsVal) < $signed(opB)};
			mipsPkg::ALU_SLTU: aluResult = {31'd0, rsVal < opB};
			mipsPkg::ALU_SLL: aluResult = rtVal << opB[4:0];
			mipsPkg::ALU_SRL: aluResult = rtVal >> opB[4:0];
			mipsPkg::ALU_SRA: aluResult = $unsigned($signed(rtVal) >>> opB[4:0]);
			mipsPkg::ALU_LUI: aluResult = {opB[15:0], 16'd0};
			default: aluResult = rsVal + opB;
		endcase
	end

	always_comb begin
		case (ctrl.flow)
			mipsPkg::FLOW_BEQ: begin
				redirectValid = (rsVal == rtVal);
				redirectPc = pcPlus4 + {simm[29:0], 2'b00};
			end
			mipsPkg::FLOW_BNE: begin
				redirectValid = (rsVal != rtVal);
				redirectPc = pcPlus4 + {simm[29:0], 2'b00};
			end
			mipsPkg::FLOW_JUMP: begin
				redirectValid = 1'b1;
				redirectPc = {pcPlus4[31:28], instr[25:0], 2'b00};
			end
			mipsPkg::FLOW_JREG: begin
				redirectValid = 1'b1;
				redirectPc = rsVal;
			end
			default: begin
				redirectValid = 1'b0;
				redirectPc = pcPlus4;
			end
		endcase
	end

	// sb data moved onto its byte lane
	assign storeData = (ctrl.memOp == mipsPkg::MEM_SB) ?
		({24'd0, rtVal[7:0]} << {aluResult[1:0], 3'b000}) : rtVal;

	assign isStore = (ctrl.memOp == mipsPkg::MEM_SW) || (ctrl.memOp == mipsPkg::MEM_SB);
	assign destAddr = ctrl.link ? 5'd31 : (ctrl.destIsRd ? instr[15:11] : rtAddr);

	always_comb begin
		execNext.result = aluResult;
		execNext.storeData = storeData;
		execNext.wbAddr = destAddr;
		execNext.regWrite = ctrl.regWrite;
		execNext.memOp = ctrl.memOp;
		execNext.link = ctrl.link;
		execNext.linkValue = pcPlus4 + 32'd4;
		execNext.isIo = isStore && (aluResult[31:28] == mipsPkg::IO_REGION);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			execOut <= '0;
		end else begin
			execOut <= execNext;
		end
	end

endmodule

// ==== logic/fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage (
	input logic clk,
	input logic reset,
	input logic progWe,
	input mipsPkg::word_t progAddr,
	input mipsPkg::word_t progData,
	input logic redirectValid,
	input mipsPkg::word_t redirectPc,
	output mipsPkg::fetchOut_t fetchOut
);

	mipsPkg::word_t imem [mipsPkg::IMEM_WORDS];
	mipsPkg::word_t pc;
	mipsPkg::word_t nextPc;

	// redirect target replaces the sequential pc after the delay slot
	assign nextPc = redirectValid ? redirectPc : pc + 32'd4;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= mipsPkg::RESET_PC;
		end else begin
			pc <= nextPc;
		end
	end

	// program load, byte address, only while held in reset
	always_ff @(posedge clk) begin
		if (reset && progWe) begin
			imem[progAddr[mipsPkg::IMEM_AW+1:2]] <= progData;
		end
	end

	// pc travels with its synchronous read
	always_ff @(posedge clk) begin
		if (reset) begin
			fetchOut <= '0;
		end else begin
			fetchOut.instr <= imem[pc[mipsPkg::IMEM_AW+1:2]];
			fetchOut.pc <= pc;
		end
	end

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input mipsPkg::regAddr_t raddr1,
	input mipsPkg::regAddr_t raddr2,
	output mipsPkg::word_t rdata1,
	output mipsPkg::word_t rdata2,
	input mipsPkg::wbPath_t wb
);

	// r0 has no storage
	mipsPkg::word_t regs [1:31];

	always_ff @(posedge clk) begin
		if (wb.regWrite && wb.wrAddr != 5'd0) begin
			regs[wb.wrAddr] <= wb.wrData;
		end
	end

	assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

// ==== logic/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
	input mipsPkg::word_t instr,
	output mipsPkg::ctrl_t ctrl
);

	logic [5:0] opcode;
	logic [5:0] funct;
	mipsPkg::regAddr_t rt;
	mipsPkg::regAddr_t rd;
	mipsPkg::regAddr_t destField;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rt = instr[20:16];
	assign rd = instr[15:11];

	always_comb begin
		ctrl.aluOp = mipsPkg::ALU_ADD;
		ctrl.srcB = mipsPkg::SRCB_RT;
		ctrl.shiftFromRs = 1'b0;
		ctrl.flow = mipsPkg::FLOW_NONE;
		ctrl.memOp = mipsPkg::MEM_NONE;
		ctrl.regWrite = 1'b0;
		ctrl.link = 1'b0;
		ctrl.destIsRd = 1'b0;

		case (opcode)
			mipsPkg::OP_RTYPE: begin
				ctrl.destIsRd = 1'b1;
				ctrl.regWrite = 1'b1;
				case (funct)
					mipsPkg::FN_ADDU: ctrl.aluOp = mipsPkg::ALU_ADD;
					mipsPkg::FN_SUBU: ctrl.aluOp = mipsPkg::ALU_SUB;
					mipsPkg::FN_AND: ctrl.aluOp = mipsPkg::ALU_AND;
					mipsPkg::FN_OR: ctrl.aluOp = mipsPkg::ALU_OR;
					mipsPkg::FN_XOR: ctrl.aluOp = mipsPkg::ALU_XOR;
					mipsPkg::FN_NOR: ctrl.aluOp = mipsPkg::ALU_NOR;
					mipsPkg::FN_SLT: ctrl.aluOp = mipsPkg::ALU_SLT;
					mipsPkg::FN_SLTU: ctrl.aluOp = mipsPkg::ALU_SLTU;
					mipsPkg::FN_SLL: begin
						ctrl.aluOp = mipsPkg::ALU_SLL;
						ctrl.srcB = mipsPkg::SRCB_SHAMT;
					end
					mipsPkg::FN_SRL: begin
						ctrl.aluOp = mipsPkg::ALU_SRL;
						ctrl.srcB = mipsPkg::SRCB_SHAMT;
					end
					mipsPkg::FN_SRA: begin
						ctrl.aluOp = mipsPkg::ALU_SRA;
						ctrl.srcB = mipsPkg::SRCB_SHAMT;
					end
					mipsPkg::FN_JR: begin
						ctrl.flow = mipsPkg::FLOW_JREG;
						ctrl.regWrite = 1'b0;
					end
					default: ctrl.regWrite = 1'b0;
				endcase
			end
			mipsPkg::OP_J: ctrl.flow = mipsPkg::FLOW_JUMP;
			mipsPkg::OP_JAL: begin
				ctrl.flow = mipsPkg::FLOW_JUMP;
				ctrl.link = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			mipsPkg::OP_BEQ: ctrl.flow = mipsPkg::FLOW_BEQ;
			mipsPkg::OP_BNE: ctrl.flow = mipsPkg::FLOW_BNE;
			mipsPkg::OP_ADDIU, mipsPkg::OP_SLTI, mipsPkg::OP_SLTIU: begin
				ctrl.srcB = mipsPkg::SRCB_SIMM;
				ctrl.regWrite = 1'b1;
				if (opcode == mipsPkg::OP_SLTI) begin
					ctrl.aluOp = mipsPkg::ALU_SLT;
				end else if (opcode == mipsPkg::OP_SLTIU) begin
					ctrl.aluOp = mipsPkg::ALU_SLTU;
				end
			end
			mipsPkg::OP_ANDI, mipsPkg::OP_ORI, mipsPkg::OP_XORI, mipsPkg::OP_LUI: begin
				ctrl.srcB = mipsPkg::SRCB_ZIMM;
				ctrl.regWrite = 1'b1;
				case (opcode)
					mipsPkg::OP_ANDI: ctrl.aluOp = mipsPkg::ALU_AND;
					mipsPkg::OP_ORI: ctrl.aluOp = mipsPkg::ALU_OR;
					mipsPkg::OP_XORI: ctrl.aluOp = mipsPkg::ALU_XOR;
					default: ctrl.aluOp = mipsPkg::ALU_LUI;
				endcase
			end
			mipsPkg::OP_LW, mipsPkg::OP_LB, mipsPkg::OP_LBU: begin
				ctrl.srcB = mipsPkg::SRCB_SIMM;
				ctrl.regWrite = 1'b1;
				case (opcode)
					mipsPkg::OP_LW: ctrl.memOp = mipsPkg::MEM_LW;
					mipsPkg::OP_LB: ctrl.memOp = mipsPkg::MEM_LB;
					default: ctrl.memOp = mipsPkg::MEM_LBU;
				endcase
			end
			mipsPkg::OP_SW: begin
				ctrl.srcB = mipsPkg::SRCB_SIMM;
				ctrl.memOp = mipsPkg::MEM_SW;
			end
			mipsPkg::OP_SB: begin
				ctrl.srcB = mipsPkg::SRCB_SIMM;
				ctrl.memOp = mipsPkg::MEM_SB;
			end
			default: ;
		endcase

		// a write to r0 is dropped here, so forwarding never sees it
		destField = ctrl.destIsRd ? rd : rt;
		if (!ctrl.link && destField == 5'd0) begin
			ctrl.regWrite = 1'b0;
		end
	end

endmodule

// ==== logic/mipsPkg.sv ====
package mipsPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [7:0] ioPort_t;

	localparam int IMEM_WORDS = 1024;
	localparam int DMEM_WORDS = 1024;
	localparam int IMEM_AW = $clog2(IMEM_WORDS);
	localparam int DMEM_AW = $clog2(DMEM_WORDS);
	localparam word_t RESET_PC = 32'h0000_0000;
	// top address nibble of the output port
	localparam logic [3:0] IO_REGION = 4'h8;

	// primary opcodes
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J = 6'h02;
	localparam logic [5:0] OP_JAL = 6'h03;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_BNE = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_SLTI = 6'h0a;
	localparam logic [5:0] OP_SLTIU = 6'h0b;
	localparam logic [5:0] OP_ANDI = 6'h0c;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_XORI = 6'h0e;
	localparam logic [5:0] OP_LUI = 6'h0f;
	localparam logic [5:0] OP_LB = 6'h20;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_LBU = 6'h24;
	localparam logic [5:0] OP_SB = 6'h28;
	localparam logic [5:0] OP_SW = 6'h2b;

	// funct codes of the register format
	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_SRL = 6'h02;
	localparam logic [5:0] FN_SRA = 6'h03;
	localparam logic [5:0] FN_JR = 6'h08;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_NOR = 6'h27;
	localparam logic [5:0] FN_SLT = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} aluOp_t;

	typedef enum logic [1:0] {SRCB_RT, SRCB_SIMM, SRCB_ZIMM, SRCB_SHAMT} srcB_t;

	typedef enum logic [2:0] {FLOW_NONE, FLOW_BEQ, FLOW_BNE, FLOW_JUMP, FLOW_JREG} flow_t;

	typedef enum logic [2:0] {MEM_NONE, MEM_LW, MEM_LB, MEM_LBU, MEM_SW, MEM_SB} memOp_t;

	typedef struct packed {
		aluOp_t aluOp;
		srcB_t srcB;
		logic shiftFromRs;
		flow_t flow;
		memOp_t memOp;
		logic regWrite;
		logic link;
		logic destIsRd;
	} ctrl_t;

	typedef struct packed {
		word_t instr;
		word_t pc;
	} fetchOut_t;

	typedef struct packed {
		word_t result;
		word_t storeData;
		regAddr_t wbAddr;
		logic regWrite;
		memOp_t memOp;
		logic link;
		word_t linkValue;
		logic isIo;
	} execOut_t;

	typedef struct packed {
		logic regWrite;
		regAddr_t wrAddr;
		word_t wrData;
	} wbPath_t;

endpackage
